/* all.f */
design/mem_pkg.sv
design/data_port_decode.sv
design/bus_arbiter.sv
design/sram_slave.sv
design/mem_subsys_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_top.sv

/* design/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter
    import mem_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    // fetch master, read only
    input  logic    fetch_ar_valid_i,
    input  rd_req_t fetch_ar_i,
    output logic    fetch_ar_ready_o,
    output logic    fetch_r_valid_o,
    output rd_rsp_t fetch_r_o,
    input  logic    fetch_r_ready_i,
    // data master, in-window traffic only
    input  logic    data_ar_valid_i,
    input  rd_req_t data_ar_i,
    output logic    data_ar_ready_o,
    output logic    data_r_valid_o,
    output rd_rsp_t data_r_o,
    input  logic    data_r_ready_i,
    input  logic    data_aw_valid_i,
    input  wr_req_t data_aw_i,
    output logic    data_aw_ready_o,
    output logic    data_b_valid_o,
    output resp_t   data_b_o,
    input  logic    data_b_ready_i,
    // shared memory bus
    output logic    mem_ar_valid_o,
    output rd_req_t mem_ar_o,
    input  logic    mem_ar_ready_i,
    input  logic    mem_r_valid_i,
    input  rd_rsp_t mem_r_i,
    output logic    mem_r_ready_o,
    output logic    mem_aw_valid_o,
    output wr_req_t mem_aw_o,
    input  logic    mem_aw_ready_i,
    input  logic    mem_b_valid_i,
    input  resp_t   mem_b_i,
    output logic    mem_b_ready_o
);

    typedef enum logic [1:0] {
        arb_idle,
        arb_fetch,
        arb_data,
        arb_write
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;

    // response payloads go to every master and only valid is steered
    assign fetch_r_o = mem_r_i;
    assign data_r_o  = mem_r_i;
    assign data_b_o  = mem_b_i;
    assign mem_aw_o  = data_aw_i;

    // ********************************************************************
    // grant and channel steering
    // ********************************************************************

    always_comb begin
        state_d          = state_q;
        mem_ar_valid_o   = 1'b0;
        mem_ar_o         = data_ar_i;
        mem_aw_valid_o   = 1'b0;
        mem_r_ready_o    = 1'b0;
        mem_b_ready_o    = 1'b0;
        fetch_ar_ready_o = 1'b0;
        fetch_r_valid_o  = 1'b0;
        data_ar_ready_o  = 1'b0;
        data_r_valid_o   = 1'b0;
        data_aw_ready_o  = 1'b0;
        data_b_valid_o   = 1'b0;

        case (state_q)
            arb_idle: begin
                // data read first, then data write, fetch last
                if (data_ar_valid_i) begin
                    mem_ar_valid_o  = 1'b1;
                    data_ar_ready_o = mem_ar_ready_i;
                    if (mem_ar_ready_i) begin
                        state_d = arb_data;
                    end
                end else if (data_aw_valid_i) begin
                    mem_aw_valid_o  = 1'b1;
                    data_aw_ready_o = mem_aw_ready_i;
                    if (mem_aw_ready_i) begin
                        state_d = arb_write;
                    end
                end else if (fetch_ar_valid_i) begin
                    mem_ar_valid_o   = 1'b1;
                    mem_ar_o         = fetch_ar_i;
                    fetch_ar_ready_o = mem_ar_ready_i;
                    if (mem_ar_ready_i) begin
                        state_d = arb_fetch;
                    end
                end
            end
            arb_fetch: begin
                fetch_r_valid_o = mem_r_valid_i;
                mem_r_ready_o   = fetch_r_ready_i;
                if (mem_r_valid_i && fetch_r_ready_i) begin
                    state_d = arb_idle;
                end
            end
            arb_data: begin
                data_r_valid_o = mem_r_valid_i;
                mem_r_ready_o  = data_r_ready_i;
                if (mem_r_valid_i && data_r_ready_i) begin
                    state_d = arb_idle;
                end
            end
            arb_write: begin
                // reads stall here until the write response is taken
                data_b_valid_o = mem_b_valid_i;
                mem_b_ready_o  = data_b_ready_i;
                if (mem_b_valid_i && data_b_ready_i) begin
                    state_d = arb_idle;
                end
            end
            default: begin
                state_d = arb_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= arb_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* design/data_port_decode.sv */
`timescale 1ns/1ps

module data_port_decode
    import mem_pkg::*;
#(
    parameter addr_t MEM_BASE  = 32'h8000_0000,
    parameter int    MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    // data port from the top level
    input  logic    data_ar_valid_i,
    input  rd_req_t data_ar_i,
    output logic    data_ar_ready_o,
    output logic    data_r_valid_o,
    output rd_rsp_t data_r_o,
    input  logic    data_r_ready_i,
    input  logic    data_aw_valid_i,
    input  wr_req_t data_aw_i,
    output logic    data_aw_ready_o,
    output logic    data_b_valid_o,
    output resp_t   data_b_o,
    input  logic    data_b_ready_i,
    // in-window traffic toward the arbiter
    output logic    mem_ar_valid_o,
    output rd_req_t mem_ar_o,
    input  logic    mem_ar_ready_i,
    input  logic    mem_r_valid_i,
    input  rd_rsp_t mem_r_i,
    output logic    mem_r_ready_o,
    output logic    mem_aw_valid_o,
    output wr_req_t mem_aw_o,
    input  logic    mem_aw_ready_i,
    input  logic    mem_b_valid_i,
    input  resp_t   mem_b_i,
    output logic    mem_b_ready_o
);

    localparam int AW = $bits(addr_t);

    // window end is one bit wider so a window at the top cannot wrap
    localparam logic [AW:0] MEM_END = {1'b0, MEM_BASE} + (AW + 1)'(WORD_BYTES * MEM_WORDS);

    localparam rd_rsp_t ERR_RSP = '{data: '0, resp: RESP_DECERR};

    logic ar_in_win;
    logic aw_in_win;
    // error responder state
    logic err_rd_pend;
    logic err_wr_pend;
    // in-window transactions still open at the arbiter
    logic mem_rd_busy;
    logic mem_wr_busy;

    function automatic logic in_window(input addr_t addr);
        return (addr >= MEM_BASE) && ({1'b0, addr} < MEM_END);
    endfunction

    assign ar_in_win = in_window(data_ar_i.addr);
    assign aw_in_win = in_window(data_aw_i.addr);

    // ********************************************************************
    // read side
    // ********************************************************************

    // an error read waits for an open memory read so responses stay in order
    assign mem_ar_valid_o  = data_ar_valid_i && ar_in_win && !err_rd_pend;
    assign mem_ar_o        = data_ar_i;
    assign data_ar_ready_o = ar_in_win ? (mem_ar_ready_i && !err_rd_pend)
                                       : (data_ar_valid_i && !err_rd_pend && !mem_rd_busy);

    assign data_r_valid_o = err_rd_pend || mem_r_valid_i;
    assign data_r_o       = err_rd_pend ? ERR_RSP : mem_r_i;
    assign mem_r_ready_o  = data_r_ready_i && !err_rd_pend;

    // ********************************************************************
    // write side
    // ********************************************************************

    assign mem_aw_valid_o  = data_aw_valid_i && aw_in_win && !err_wr_pend;
    assign mem_aw_o        = data_aw_i;
    assign data_aw_ready_o = aw_in_win ? (mem_aw_ready_i && !err_wr_pend)
                                       : (data_aw_valid_i && !err_wr_pend && !mem_wr_busy);

    assign data_b_valid_o = err_wr_pend || mem_b_valid_i;
    assign data_b_o       = err_wr_pend ? RESP_DECERR : mem_b_i;
    assign mem_b_ready_o  = data_b_ready_i && !err_wr_pend;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            err_rd_pend <= 1'b0;
            err_wr_pend <= 1'b0;
            mem_rd_busy <= 1'b0;
            mem_wr_busy <= 1'b0;
        end else begin
            // out-of-window read answered the cycle after acceptance
            if (data_ar_valid_i && data_ar_ready_o && !ar_in_win) begin
                err_rd_pend <= 1'b1;
            end else if (err_rd_pend && data_r_ready_i) begin
                err_rd_pend <= 1'b0;
            end
            if (data_aw_valid_i && data_aw_ready_o && !aw_in_win) begin
                err_wr_pend <= 1'b1;
            end else if (err_wr_pend && data_b_ready_i) begin
                err_wr_pend <= 1'b0;
            end
            if (mem_ar_valid_o && mem_ar_ready_i) begin
                mem_rd_busy <= 1'b1;
            end else if (mem_r_valid_i && mem_r_ready_o) begin
                mem_rd_busy <= 1'b0;
            end
            if (mem_aw_valid_o && mem_aw_ready_i) begin
                mem_wr_busy <= 1'b1;
            end else if (mem_b_valid_i && mem_b_ready_o) begin
                mem_wr_busy <= 1'b0;
            end
        end
    end

endmodule

/* design/mem_pkg.sv */
package mem_pkg;

    // ********************************************************************
    // bus widths
    // ********************************************************************

    // byte address on every channel
    typedef logic [31:0] addr_t;

    // one 64-bit bus word
    typedef logic [63:0] data_t;

    // one strobe bit per data byte
    typedef logic [7:0] strb_t;

    // response code on r and b
    typedef logic [1:0] resp_t;

    // bytes in one bus word and the address step between words
    localparam int WORD_BYTES = $bits(data_t) / 8;

    // ********************************************************************
    // response codes
    // ********************************************************************

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

    // ********************************************************************
    // channel payloads
    // ********************************************************************

    // ar channel
    typedef struct packed {
        addr_t addr;
    } rd_req_t;

    // r channel
    typedef struct packed {
        data_t data;
        resp_t resp;
    } rd_rsp_t;

    // aw and w merged into one request
    typedef struct packed {
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_req_t;

endpackage

/* design/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top
    import mem_pkg::*;
#(
    parameter addr_t MEM_BASE  = 32'h8000_0000,
    parameter int    MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    // fetch port
    input  logic    fetch_ar_valid_i,
    input  rd_req_t fetch_ar_i,
    output logic    fetch_ar_ready_o,
    output logic    fetch_r_valid_o,
    output rd_rsp_t fetch_r_o,
    input  logic    fetch_r_ready_i,
    // data port
    input  logic    data_ar_valid_i,
    input  rd_req_t data_ar_i,
    output logic    data_ar_ready_o,
    output logic    data_r_valid_o,
    output rd_rsp_t data_r_o,
    input  logic    data_r_ready_i,
    input  logic    data_aw_valid_i,
    input  wr_req_t data_aw_i,
    output logic    data_aw_ready_o,
    output logic    data_b_valid_o,
    output resp_t   data_b_o,
    input  logic    data_b_ready_i
);

    // decode to arbiter
    logic    dec_ar_valid;
    rd_req_t dec_ar;
    logic    dec_ar_ready;
    logic    dec_r_valid;
    rd_rsp_t dec_r;
    logic    dec_r_ready;
    logic    dec_aw_valid;
    wr_req_t dec_aw;
    logic    dec_aw_ready;
    logic    dec_b_valid;
    resp_t   dec_b;
    logic    dec_b_ready;

    // arbiter to sram
    logic    sram_ar_valid;
    rd_req_t sram_ar;
    logic    sram_ar_ready;
    logic    sram_r_valid;
    rd_rsp_t sram_r;
    logic    sram_r_ready;
    logic    sram_aw_valid;
    wr_req_t sram_aw;
    logic    sram_aw_ready;
    logic    sram_b_valid;
    resp_t   sram_b;
    logic    sram_b_ready;

    data_port_decode #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_ar_valid_i (data_ar_valid_i),
        .data_ar_i       (data_ar_i),
        .data_ar_ready_o (data_ar_ready_o),
        .data_r_valid_o  (data_r_valid_o),
        .data_r_o        (data_r_o),
        .data_r_ready_i  (data_r_ready_i),
        .data_aw_valid_i (data_aw_valid_i),
        .data_aw_i       (data_aw_i),
        .data_aw_ready_o (data_aw_ready_o),
        .data_b_valid_o  (data_b_valid_o),
        .data_b_o        (data_b_o),
        .data_b_ready_i  (data_b_ready_i),
        .mem_ar_valid_o  (dec_ar_valid),
        .mem_ar_o        (dec_ar),
        .mem_ar_ready_i  (dec_ar_ready),
        .mem_r_valid_i   (dec_r_valid),
        .mem_r_i         (dec_r),
        .mem_r_ready_o   (dec_r_ready),
        .mem_aw_valid_o  (dec_aw_valid),
        .mem_aw_o        (dec_aw),
        .mem_aw_ready_i  (dec_aw_ready),
        .mem_b_valid_i   (dec_b_valid),
        .mem_b_i         (dec_b),
        .mem_b_ready_o   (dec_b_ready)
    );

    bus_arbiter u_arbiter (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_ar_valid_i (fetch_ar_valid_i),
        .fetch_ar_i       (fetch_ar_i),
        .fetch_ar_ready_o (fetch_ar_ready_o),
        .fetch_r_valid_o  (fetch_r_valid_o),
        .fetch_r_o        (fetch_r_o),
        .fetch_r_ready_i  (fetch_r_ready_i),
        .data_ar_valid_i  (dec_ar_valid),
        .data_ar_i        (dec_ar),
        .data_ar_ready_o  (dec_ar_ready),
        .data_r_valid_o   (dec_r_valid),
        .data_r_o         (dec_r),
        .data_r_ready_i   (dec_r_ready),
        .data_aw_valid_i  (dec_aw_valid),
        .data_aw_i        (dec_aw),
        .data_aw_ready_o  (dec_aw_ready),
        .data_b_valid_o   (dec_b_valid),
        .data_b_o         (dec_b),
        .data_b_ready_i   (dec_b_ready),
        .mem_ar_valid_o   (sram_ar_valid),
        .mem_ar_o         (sram_ar),
        .mem_ar_ready_i   (sram_ar_ready),
        .mem_r_valid_i    (sram_r_valid),
        .mem_r_i          (sram_r),
        .mem_r_ready_o    (sram_r_ready),
        .mem_aw_valid_o   (sram_aw_valid),
        .mem_aw_o         (sram_aw),
        .mem_aw_ready_i   (sram_aw_ready),
        .mem_b_valid_i    (sram_b_valid),
        .mem_b_i          (sram_b),
        .mem_b_ready_o    (sram_b_ready)
    );

    sram_slave #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk        (clk),
        .rst_n      (rst_n),
        .ar_valid_i (sram_ar_valid),
        .ar_i       (sram_ar),
        .ar_ready_o (sram_ar_ready),
        .r_valid_o  (sram_r_valid),
        .r_o        (sram_r),
        .r_ready_i  (sram_r_ready),
        .aw_valid_i (sram_aw_valid),
        .aw_i       (sram_aw),
        .aw_ready_o (sram_aw_ready),
        .b_valid_o  (sram_b_valid),
        .b_o        (sram_b),
        .b_ready_i  (sram_b_ready)
    );

endmodule

/* design/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave
    import mem_pkg::*;
#(
    parameter addr_t MEM_BASE  = 32'h8000_0000,
    parameter int    MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    // read request and response
    input  logic    ar_valid_i,
    input  rd_req_t ar_i,
    output logic    ar_ready_o,
    output logic    r_valid_o,
    output rd_rsp_t r_o,
    input  logic    r_ready_i,
    // write request and response
    input  logic    aw_valid_i,
    input  wr_req_t aw_i,
    output logic    aw_ready_o,
    output logic    b_valid_o,
    output resp_t   b_o,
    input  logic    b_ready_i
);

    localparam int IDX_W   = $clog2(MEM_WORDS);
    localparam int OFF_LSB = $clog2(WORD_BYTES);

    typedef logic [IDX_W-1:0] word_idx_t;

    typedef enum logic [1:0] {
        sram_idle,
        sram_read_resp,
        sram_write_resp
    } sram_state_t;

    sram_state_t state_q;
    data_t       mem_q [MEM_WORDS];
    data_t       rdata_q;
    logic        rd_fire;
    logic        wr_fire;

    // word index from the byte offset within the window
    function automatic word_idx_t word_index(input addr_t addr);
        addr_t offset;
        offset = addr - MEM_BASE;
        return offset[OFF_LSB +: IDX_W];
    endfunction

    // power-up contents
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    // ********************************************************************
    // handshakes
    // ********************************************************************

    // a read wins when both requests arrive together
    assign ar_ready_o = (state_q == sram_idle);
    assign aw_ready_o = (state_q == sram_idle) && !ar_valid_i;

    assign rd_fire = ar_valid_i && ar_ready_o;
    assign wr_fire = aw_valid_i && aw_ready_o;

    assign r_valid_o = (state_q == sram_read_resp);
    assign r_o       = '{data: rdata_q, resp: RESP_OKAY};
    assign b_valid_o = (state_q == sram_write_resp);
    assign b_o       = RESP_OKAY;

    always_ff @(posedge clk) begin
        if (rst_n) begin
            state_q <= sram_idle;
        end else begin
            case (state_q)
                sram_idle: begin
                    if (rd_fire) begin
                        state_q <= sram_read_resp;
                    end else if (wr_fire) begin
                        state_q <= sram_write_resp;
                    end
                end
                sram_read_resp: begin
                    if (r_ready_i) begin
                        state_q <= sram_idle;
                    end
                end
                sram_write_resp: begin
                    if (b_ready_i) begin
                        state_q <= sram_idle;
                    end
                end
                default: begin
                    state_q <= sram_idle;
                end
            endcase
        end
    end

    // ********************************************************************
    // storage
    // ********************************************************************

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata_q <= mem_q[word_index(ar_i.addr)];
        end
        // byte lanes with strobe low keep their old value
        if (wr_fire) begin
            for (int b = 0; b < WORD_BYTES; b++) begin
                if (aw_i.strb[b]) begin
                    mem_q[word_index(aw_i.addr)][b*8 +: 8] <= aw_i.data[b*8 +: 8];
                end
            end
        end
    end

endmodule

/* test/tb_checker.sv */
`timescale 1ns/1ps

module tb_checker
    import mem_pkg::*;
#(
    parameter addr_t MEM_BASE  = 32'h8000_0000,
    parameter int    MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    fetch_ar_valid_i,
    input  rd_req_t fetch_ar_i,
    input  logic    fetch_ar_ready_i,
    input  logic    fetch_r_valid_i,
    input  rd_rsp_t fetch_r_i,
    input  logic    fetch_r_ready_i,
    input  logic    data_ar_valid_i,
    input  rd_req_t data_ar_i,
    input  logic    data_ar_ready_i,
    input  logic    data_r_valid_i,
    input  rd_rsp_t data_r_i,
    input  logic    data_r_ready_i,
    input  logic    data_aw_valid_i,
    input  wr_req_t data_aw_i,
    input  logic    data_aw_ready_i,
    input  logic    data_b_valid_i,
    input  resp_t   data_b_i,
    input  logic    data_b_ready_i,
    output int      fetch_err_o,
    output int      data_err_o,
    output int      proto_err_o
);

    // reference memory, one entry per 8-byte word
    data_t   model [MEM_WORDS];
    // expected responses in request order
    rd_rsp_t fetch_exp_q [$];
    rd_rsp_t data_rd_exp_q [$];
    resp_t   data_wr_exp_q [$];
    rd_rsp_t data_rd_exp;
    resp_t   data_wr_exp;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            model[i] = '0;
        end
    end

    function automatic bit in_window(input addr_t addr);
        longint lo;
        longint hi;
        lo = longint'(MEM_BASE);
        hi = lo + 8 * longint'(MEM_WORDS);
        return (longint'(addr) >= lo) && (longint'(addr) < hi);
    endfunction

    // outside the window the answer is DECERR with zero data
    function automatic rd_rsp_t expected_read(input addr_t addr);
        rd_rsp_t rsp;
        rsp.data = '0;
        rsp.resp = RESP_DECERR;
        if (in_window(addr)) begin
            rsp.data = model[(addr - MEM_BASE) / 8];
            rsp.resp = RESP_OKAY;
        end
        return rsp;
    endfunction

    task automatic apply_write(input wr_req_t req);
        int idx;
        if (in_window(req.addr)) begin
            idx = (req.addr - MEM_BASE) / 8;
            for (int b = 0; b < 8; b++) begin
                if (req.strb[b]) begin
                    model[idx][b*8 +: 8] = req.data[b*8 +: 8];
                end
            end
        end
    endtask

    function automatic int read_mismatch(input string name, input rd_rsp_t exp,
                                         input rd_rsp_t act);
        if (act === exp) begin
            return 0;
        end
        $display("CHECK FAILED %s at %0t: expected data %h resp %0d, actual data %h resp %0d",
                 name, $time, exp.data, exp.resp, act.data, act.resp);
        return 1;
    endfunction

    // ********************************************************************
    // monitor sampled mid-cycle where every port is settled
    // ********************************************************************

    always @(negedge clk) begin
        if (!rst_n) begin
            // responses first since a request of this cycle cannot be answered yet
            if (fetch_r_valid_i && fetch_exp_q.size() == 0) begin
                $display("fetch r valid at %0t with no fetch read outstanding", $time);
                proto_err_o++;
            end else if (fetch_r_valid_i && fetch_r_ready_i) begin
                fetch_err_o += read_mismatch("fetch_read", fetch_exp_q.pop_front(), fetch_r_i);
            end
            if (data_r_valid_i && data_rd_exp_q.size() == 0) begin
                $display("data r valid at %0t with no data read outstanding", $time);
                proto_err_o++;
            end else if (data_r_valid_i && data_r_ready_i) begin
                data_rd_exp = data_rd_exp_q.pop_front();
                data_err_o += read_mismatch(
                    data_rd_exp.resp == RESP_OKAY ? "data_read" : "data_read_outside",
                    data_rd_exp, data_r_i);
            end
            if (data_b_valid_i && data_wr_exp_q.size() == 0) begin
                $display("data b valid at %0t with no data write outstanding", $time);
                proto_err_o++;
            end else if (data_b_valid_i && data_b_ready_i) begin
                data_wr_exp = data_wr_exp_q.pop_front();
                if (data_b_i !== data_wr_exp) begin
                    $display("CHECK FAILED data_write at %0t: expected resp %0d, actual resp %0d",
                             $time, data_wr_exp, data_b_i);
                    data_err_o++;
                end
            end
            // reads take the model word before a write of the same cycle lands
            if (fetch_ar_valid_i && fetch_ar_ready_i) begin
                fetch_exp_q.push_back(expected_read(fetch_ar_i.addr));
            end
            if (data_ar_valid_i && data_ar_ready_i) begin
                data_rd_exp_q.push_back(expected_read(data_ar_i.addr));
            end
            if (data_aw_valid_i && data_aw_ready_i) begin
                data_wr_exp_q.push_back(in_window(data_aw_i.addr) ? RESP_OKAY : RESP_DECERR);
                apply_write(data_aw_i);
            end
        end
    end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

/* test/tb_top.sv */
`timescale 1ns/1ps

module tb_top
    import mem_pkg::*;
#(
    parameter int N_FETCH = 200,
    parameter int N_DATA  = 300
) ();

    localparam addr_t MEM_BASE       = 32'h8000_0000;
    localparam int    MEM_WORDS      = 256;
    localparam int    DRIVE_DLY      = 1;
    localparam int    TIMEOUT_CYCLES = (N_FETCH + N_DATA) * 20;
    localparam logic [31:0] LFSR_SEED = 32'd44;
    // x^32 + x^31 + x^29 + x + 1, right-shifting form
    localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

    logic    clk;
    logic    rst_n;
    logic    fetch_ar_valid_i;
    rd_req_t fetch_ar_i;
    logic    fetch_ar_ready_o;
    logic    fetch_r_valid_o;
    rd_rsp_t fetch_r_o;
    logic    fetch_r_ready_i;
    logic    data_ar_valid_i;
    rd_req_t data_ar_i;
    logic    data_ar_ready_o;
    logic    data_r_valid_o;
    rd_rsp_t data_r_o;
    logic    data_r_ready_i;
    logic    data_aw_valid_i;
    wr_req_t data_aw_i;
    logic    data_aw_ready_o;
    logic    data_b_valid_o;
    resp_t   data_b_o;
    logic    data_b_ready_i;

    logic [31:0] lfsr_q;
    // handshakes that complete at the coming rising edge
    logic fetch_ar_fire;
    logic fetch_r_fire;
    logic data_ar_fire;
    logic data_r_fire;
    logic data_aw_fire;
    logic data_b_fire;
    // one outstanding request per port
    logic fetch_wait;
    logic data_wait;
    int   fetch_issued;
    int   fetch_done;
    int   data_issued;
    int   data_done;
    int   fetch_err;
    int   data_err;
    int   proto_err;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk_o(clk));

    mem_subsys_top #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (.*);

    tb_checker #(
        .MEM_BASE  (MEM_BASE),
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_ar_valid_i (fetch_ar_valid_i),
        .fetch_ar_i       (fetch_ar_i),
        .fetch_ar_ready_i (fetch_ar_ready_o),
        .fetch_r_valid_i  (fetch_r_valid_o),
        .fetch_r_i        (fetch_r_o),
        .fetch_r_ready_i  (fetch_r_ready_i),
        .data_ar_valid_i  (data_ar_valid_i),
        .data_ar_i        (data_ar_i),
        .data_ar_ready_i  (data_ar_ready_o),
        .data_r_valid_i   (data_r_valid_o),
        .data_r_i         (data_r_o),
        .data_r_ready_i   (data_r_ready_i),
        .data_aw_valid_i  (data_aw_valid_i),
        .data_aw_i        (data_aw_i),
        .data_aw_ready_i  (data_aw_ready_o),
        .data_b_valid_i   (data_b_valid_o),
        .data_b_i         (data_b_o),
        .data_b_ready_i   (data_b_ready_i),
        .fetch_err_o      (fetch_err),
        .data_err_o       (data_err),
        .proto_err_o      (proto_err)
    );

    // ********************************************************************
    // random source
    // ********************************************************************

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val    = {val[62:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return val;
    endfunction

    // lowest or highest 32 words so both window edges see traffic
    function automatic addr_t window_addr();
        int idx;
        idx = int'(rand_bits(5));
        if (rand_bits(1) != 0) begin
            idx = idx + MEM_WORDS - 32;
        end
        return MEM_BASE + addr_t'(idx * 8);
    endfunction

    // just past either end of the window
    function automatic addr_t outside_addr();
        addr_t off;
        off = addr_t'(rand_bits(4)) * 8;
        if (rand_bits(1) != 0) begin
            return MEM_BASE + addr_t'(MEM_WORDS * 8) + off;
        end
        return MEM_BASE - 8 - off;
    endfunction

    // ********************************************************************
    // port drivers
    // ********************************************************************

    task automatic sample_fires();
        fetch_ar_fire = fetch_ar_valid_i && fetch_ar_ready_o;
        fetch_r_fire  = fetch_r_valid_o && fetch_r_ready_i;
        data_ar_fire  = data_ar_valid_i && data_ar_ready_o;
        data_r_fire   = data_r_valid_o && data_r_ready_i;
        data_aw_fire  = data_aw_valid_i && data_aw_ready_o;
        data_b_fire   = data_b_valid_o && data_b_ready_i;
    endtask

    task automatic drive_fetch();
        if (fetch_ar_fire) begin
            fetch_ar_valid_i = 1'b0;
            fetch_wait       = 1'b1;
        end
        if (fetch_r_fire) begin
            fetch_wait = 1'b0;
            fetch_done++;
        end
        // ready three cycles in four
        fetch_r_ready_i = (rand_bits(2) != 0);
        if (!fetch_ar_valid_i && !fetch_wait && fetch_issued < N_FETCH
                && rand_bits(1) != 0) begin
            fetch_ar_i.addr  = window_addr();
            fetch_ar_valid_i = 1'b1;
            fetch_issued++;
        end
    endtask

    task automatic drive_data();
        addr_t addr;
        if (data_ar_fire || data_aw_fire) begin
            data_ar_valid_i = 1'b0;
            data_aw_valid_i = 1'b0;
            data_wait       = 1'b1;
        end
        if (data_r_fire || data_b_fire) begin
            data_wait = 1'b0;
            data_done++;
        end
        data_r_ready_i = (rand_bits(2) != 0);
        data_b_ready_i = (rand_bits(2) != 0);
        if (!data_ar_valid_i && !data_aw_valid_i && !data_wait && data_issued < N_DATA
                && rand_bits(1) != 0) begin
            // in-window three times in four
            if (rand_bits(2) != 0) begin
                addr = window_addr();
            end else begin
                addr = outside_addr();
            end
            if (rand_bits(1) != 0) begin
                data_aw_i.addr  = addr;
                data_aw_i.data  = rand_bits(64);
                data_aw_i.strb  = strb_t'(rand_bits(8));
                data_aw_valid_i = 1'b1;
            end else begin
                data_ar_i.addr  = addr;
                data_ar_valid_i = 1'b1;
            end
            data_issued++;
        end
    endtask

    // ********************************************************************
    // sequence
    // ********************************************************************

    initial begin
        lfsr_q           = LFSR_SEED;
        rst_n            = 1'b1;
        fetch_ar_valid_i = 1'b0;
        fetch_ar_i       = '0;
        fetch_r_ready_i  = 1'b0;
        data_ar_valid_i  = 1'b0;
        data_ar_i        = '0;
        data_r_ready_i   = 1'b0;
        data_aw_valid_i  = 1'b0;
        data_aw_i        = '0;
        data_b_ready_i   = 1'b0;
        fetch_wait       = 1'b0;
        data_wait        = 1'b0;

        repeat (2) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b0;

        // all top valids must stay low in this quiet stretch
        repeat (4) @(posedge clk);

        while (fetch_done < N_FETCH || data_done < N_DATA) begin
            @(negedge clk);
            sample_fires();
            @(posedge clk);
            #DRIVE_DLY;
            drive_fetch();
            drive_data();
        end
        repeat (4) @(posedge clk);

        $display("%0d fetches, %0d data accesses, errors: fetch %0d, data %0d, protocol %0d",
                 fetch_done, data_done, fetch_err, data_err, proto_err);
        if (fetch_err + data_err + proto_err == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // watchdog that also catches a starved fetch port
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles: %0d of %0d fetches and %0d of %0d data accesses done",
                 TIMEOUT_CYCLES, fetch_done, N_FETCH, data_done, N_DATA);
        $display("test failed");
        $finish;
    end

endmodule
